// ==== Bender.yml ====
package:
  name: digitizer_core

sources:
  - logic/digitizer_pkg.sv
  - logic/cmd_receiver.sv
  - logic/sample_frontend.sv
  - logic/acq_trigger.sv
  - logic/sample_buffer.sv
  - logic/cmd_processor.sv
  - logic/digitizer_top.sv
  - target: simulation
    files:
      - dv/digitizer_tb.sv

// ==== all.f ====
logic/digitizer_pkg.sv
logic/cmd_receiver.sv
logic/sample_frontend.sv
logic/acq_trigger.sv
logic/sample_buffer.sv
logic/cmd_processor.sv
logic/digitizer_top.sv
dv/digitizer_tb.sv

// ==== dv/digitizer_tb.sv ====
//----------------------------------------------------------------------
// testbench for the digitizer core with ramp samples and random tx back-pressure
// the first readout spans the whole ring, so the -2048 saturation is always hit
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module digitizer_tb;

	localparam int          TIMEOUT     = 200;          // cycles per handshake wait
	localparam int          MAX_POLLS   = 40;           // arm polls before giving up
	localparam logic [31:0] EXP_VERSION = 32'd18;
	localparam logic [31:0] LFSR_SEED   = 32'hf485_1ff2;

	logic        clk;
	logic        rstn;
	logic        i_rx_valid;
	logic [7:0]  i_rx_data;
	logic        o_rx_ready;
	logic        o_tx_valid;
	logic [31:0] o_tx_data;
	logic [3:0]  o_tx_keep;
	logic        o_tx_last;
	logic        i_tx_ready;
	logic [47:0] i_adc_samples;

	logic [31:0] beat_q [$];   // accepted reply beats
	logic [3:0]  keep_q [$];
	logic        last_q [$];
	logic [31:0] lfsr;         // back-pressure source
	int          sample_cycle; // k of the ramp
	logic        use_const;    // all lanes at const_raw instead of the ramp
	logic [11:0] const_raw;
	logic [7:0]  exp_events;   // events the host should see
	logic        stall_seen;   // beat was offered but not taken
	logic [31:0] stall_data;
	logic [3:0]  stall_keep;
	logic        stall_last;

	digitizer_top dut (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .o_rx_ready(o_rx_ready),
		.o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_keep(o_tx_keep),
		.o_tx_last(o_tx_last), .i_tx_ready(i_tx_ready),
		.i_adc_samples(i_adc_samples)
	);

	//------------------------------------------------------------------
	// reference model
	//------------------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
	endfunction

	function automatic logic [11:0] ramp_raw(input int n);
		int m;
		m = -n;
		return m[11:0]; // raw lane value with 12 bit wrap
	endfunction

	function automatic logic [47:0] ramp_word(input int k);
		logic [47:0] w;
		for (int j = 0; j < 4; j++) w[j*12 +: 12] = ramp_raw(4 * k + j);
		return w;
	endfunction

	// expected stored sample since the adc input is inverted
	function automatic logic [11:0] stored_of(input logic [11:0] raw);
		if (raw == 12'h800) return 12'h7ff; // -2048 saturates
		return ~raw + 12'd1;
	endfunction

	function automatic logic [11:0] raw_for(input int stored);
		int m;
		m = -stored;
		return m[11:0];
	endfunction

	function automatic int thresh(input int level, input int hyst);
		return 16 * (level + hyst - 128) + 8;
	endfunction

	// ramp index of a lane-0 sample or -1 if none
	function automatic int find_base(input logic [11:0] v0);
		for (int n = 0; n < 4096; n += 4) begin
			if (stored_of(ramp_raw(n)) == v0) return n;
		end
		return -1;
	endfunction

	function automatic logic [63:0] settings_cmd(input logic [7:0] level, input logic [7:0] hyst,
		input logic [9:0] preoff, input logic [7:0] tot);
		return {16'h0, tot, preoff[7:0], 6'd0, preoff[9:8], hyst, level,
			digitizer_pkg::OP_TRIG_SET};
	endfunction

	function automatic logic [63:0] arm_cmd(input logic [7:0] ttype, input logic [15:0] plen);
		return {16'h0, plen, 16'h0, ttype, digitizer_pkg::OP_ARM};
	endfunction

	function automatic logic [63:0] readout_cmd(input logic [31:0] len);
		return {len, 24'h0, digitizer_pkg::OP_READOUT};
	endfunction

	//------------------------------------------------------------------
	// checks and failure reporting
	//------------------------------------------------------------------
	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_with(input string what);
		$display("t=%0t %s", $time, what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	//------------------------------------------------------------------
	// clock, sample ramp, back-pressure and reply monitor
	//------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		sample_cycle  <= sample_cycle + 1;
		i_adc_samples <= use_const ? {4{const_raw}} : ramp_word(sample_cycle + 1);
		lfsr          <= lfsr_step(lfsr);
		i_tx_ready    <= lfsr[31]; // one bit per step
	end

	// beats must hold while stalled and accepted beats are queued
	always @(posedge clk) begin
		if (stall_seen) begin
			check_value("o_tx_valid held", o_tx_valid, 1'b1);
			check_value("o_tx_data held", o_tx_data, stall_data);
			check_value("o_tx_keep held", o_tx_keep, stall_keep);
			check_value("o_tx_last held", o_tx_last, stall_last);
		end
		stall_seen = rstn && o_tx_valid && !i_tx_ready;
		stall_data = o_tx_data;
		stall_keep = o_tx_keep;
		stall_last = o_tx_last;
		if (rstn && o_tx_valid && i_tx_ready) begin
			beat_q.push_back(o_tx_data);
			keep_q.push_back(o_tx_keep);
			last_q.push_back(o_tx_last);
		end
	end

	//------------------------------------------------------------------
	// host side tasks that all start and end on a rising edge
	//------------------------------------------------------------------
	task automatic send_cmd(input logic [63:0] cmd);
		int  t;
		logic took;
		for (int i = 0; i < 8; i++) begin
			i_rx_valid <= 1'b1;
			i_rx_data  <= cmd[8*i +: 8]; // first byte is the opcode
			t = 0;
			do begin
				@(posedge clk);
				t++;
				took = o_rx_ready;
			end while (!took && t < TIMEOUT);
			if (!took) fail_with("command byte was not accepted in time");
		end
		i_rx_valid <= 1'b0;
	endtask

	task automatic clear_replies();
		beat_q.delete();
		keep_q.delete();
		last_q.delete();
	endtask

	task automatic run_cmd(input logic [63:0] cmd, input int n, input int limit);
		int t;
		clear_replies();
		send_cmd(cmd);
		t = 0;
		while (beat_q.size() < n && t < limit) begin
			@(posedge clk);
			t++;
		end
		if (beat_q.size() < n) fail_with("reply beats did not arrive in time");
	endtask

	task automatic word_reply(input logic [63:0] cmd, output logic [31:0] w);
		run_cmd(cmd, 1, TIMEOUT);
		check_value("o_tx_keep", keep_q[0], 4'hf);
		check_value("o_tx_last", last_q[0], 1'b1);
		w = beat_q[0];
	endtask

	task automatic arm_status(input logic [7:0] ttype, input logic [15:0] plen,
		output logic [7:0] st, output logic [7:0] ev);
		logic [31:0] w;
		word_reply(arm_cmd(ttype, plen), w);
		check_value("status pad", w[23:8], 16'h0);
		st = w[7:0];
		ev = w[31:24];
	endtask

	// arm with an unknown type only reads the status back
	task automatic expect_idle();
		logic [7:0] st;
		logic [7:0] ev;
		arm_status(8'hff, 16'd0, st, ev);
		check_value("idle state", st, digitizer_pkg::ACQ_IDLE);
	endtask

	task automatic wait_event_ready(input logic [7:0] ttype, input logic [15:0] plen);
		logic [7:0] st;
		logic [7:0] ev;
		int polls;
		polls = 0;
		do begin
			arm_status(ttype, plen, st, ev); // same length while the post count still runs
			polls++;
		end while (st != digitizer_pkg::ACQ_READY && polls < MAX_POLLS);
		if (st != digitizer_pkg::ACQ_READY) fail_with("acquisition never reached ready");
		exp_events = exp_events + 8'd1;
		check_value("event count", ev, exp_events);
	endtask

	task automatic readout_beats(input int len);
		int nb;
		int rem;
		nb = (len + 3) / 4;
		run_cmd(readout_cmd(len), nb, TIMEOUT + 20 * nb);
		for (int b = 0; b < nb; b++) begin
			rem = len - 4 * b;
			check_value("o_tx_keep", keep_q[b], (rem >= 4) ? 4'hf : 4'((1 << rem) - 1));
			check_value("o_tx_last", last_q[b], b == nb - 1);
		end
	endtask

	// stored samples run lane 0..3 and then on into the next word
	task automatic check_ramp(input int len);
		logic [11:0] smp [$];
		logic [31:0] b;
		int n0;
		for (int i = 0; i < beat_q.size(); i++) begin
			b = beat_q[i];
			for (int h = 0; h < 2; h++) begin
				if (4 * i + 2 * h + 2 <= len) begin // whole sample inside keep
					check_value("sample pad", b[16*h+12 +: 4], 4'h0);
					smp.push_back(b[16*h +: 12]);
				end
			end
		end
		n0 = find_base(smp[0]);
		if (n0 < 0) fail_with("first readout sample is not a ramp value");
		for (int s = 0; s < smp.size(); s++) begin
			check_value("readout sample", smp[s], stored_of(ramp_raw(n0 + s)));
		end
	endtask

	// mid keeps the FSM waiting while pulse arms the edge for one cycle and hold fires it
	task automatic threshold_case(input logic [7:0] ttype, input logic [7:0] wait_state,
		input int mid, input int pulse, input int hold);
		logic [7:0] st;
		logic [7:0] ev;
		const_raw <= raw_for(mid);
		use_const <= 1'b1;
		repeat (10) @(posedge clk); // through the front end register
		arm_status(ttype, 16'd4, st, ev);
		check_value("arm state", st, digitizer_pkg::ACQ_IDLE);
		check_value("event count", ev, exp_events);
		repeat (50) @(posedge clk);
		arm_status(ttype, 16'd4, st, ev);
		check_value("waiting state", st, wait_state);
		const_raw <= raw_for(pulse);
		@(posedge clk);
		const_raw <= raw_for(hold);
		wait_event_ready(ttype, 16'd4);
		readout_beats(6); // releases the event
		expect_idle();
	endtask

	//------------------------------------------------------------------
	// test sequence
	//------------------------------------------------------------------
	initial begin : main_seq
		logic [31:0] w;
		logic [7:0]  st;
		logic [7:0]  ev;
		int          lower;
		int          upper;
		rstn          = 1'b0;
		i_rx_valid    = 1'b0;
		i_rx_data     = 8'h0;
		i_tx_ready    = 1'b0;
		lfsr          = LFSR_SEED;
		sample_cycle  = 0;
		use_const     = 1'b0;
		const_raw     = 12'h0;
		i_adc_samples = ramp_word(0);
		exp_events    = 8'd0;
		stall_seen    = 1'b0;
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		check_value("o_tx_valid after reset", o_tx_valid, 1'b0);

		word_reply({56'h0, digitizer_pkg::OP_VERSION}, w);
		check_value("version reply", w, EXP_VERSION);

		// level 128 and hyst 16 with pre-offset 1022 back to the oldest ring word
		word_reply(settings_cmd(8'd128, 8'd16, 10'd1022, 8'd5), w);
		check_value("settings reply", w, 32'd8);
		repeat (1100) @(posedge clk); // whole ring holds ramp words
		arm_status(digitizer_pkg::TRIG_IMMEDIATE, 16'd0, st, ev);
		check_value("arm state", st, digitizer_pkg::ACQ_IDLE);
		check_value("event count", ev, exp_events);
		wait_event_ready(digitizer_pkg::TRIG_IMMEDIATE, 16'd0);

		readout_beats(8191); // 1024 words with a partial last beat
		check_ramp(8191);
		expect_idle();

		lower = thresh(128, -16);
		upper = thresh(128, 16);
		threshold_case(digitizer_pkg::TRIG_RISING, digitizer_pkg::ACQ_WAIT_LOW,
			(lower + upper) / 2, lower - 64, upper + 64);
		threshold_case(digitizer_pkg::TRIG_FALLING, digitizer_pkg::ACQ_WAIT_HIGH_F,
			(lower + upper) / 2, upper + 64, lower - 64);

		clear_replies();
		send_cmd(64'h55); // no such opcode
		for (int t = 0; t < TIMEOUT; t++) begin
			@(posedge clk);
			if (beat_q.size() != 0) fail_with("unknown opcode produced a reply");
		end
		word_reply({56'h0, digitizer_pkg::OP_VERSION}, w);
		check_value("version reply", w, EXP_VERSION);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/acq_trigger.sv ====
//--------------------------------------------------------------------
// acquisition FSM, writes the ring buffer every cycle until an event
// is complete; thresholds are signed and compared on all four lanes
// unknown trigger types leave the FSM idle
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module acq_trigger (
	input  logic                                      clk,
	input  logic                                      rstn,
	input  logic [digitizer_pkg::WORD_W-1:0]          i_samples,
	input  logic                                      i_arm,
	input  logic [7:0]                                i_trig_type,
	input  logic signed [digitizer_pkg::SAMPLE_W-1:0] i_lower_thresh,
	input  logic signed [digitizer_pkg::SAMPLE_W-1:0] i_upper_thresh,
	input  logic [7:0]                                i_tot,
	input  logic [15:0]                               i_post_len,
	input  logic                                      i_readout_done,
	output logic                                      o_wr_en,
	output logic [digitizer_pkg::BUF_ADDR_W-1:0]      o_wr_addr,
	output logic [7:0]                                o_acq_state,
	output logic [7:0]                                o_event_count,
	output logic [digitizer_pkg::BUF_ADDR_W-1:0]      o_trig_addr
);

	logic signed [digitizer_pkg::SAMPLE_W-1:0] lane [digitizer_pkg::N_LANES];
	logic        any_below;  // some lane under the lower threshold
	logic        any_above;  // some lane over the upper threshold
	logic        tot_hit;    // condition of the time-over-threshold states
	logic [7:0]  tot_cnt;    // consecutive cycles with tot_hit
	logic [15:0] post_cnt;   // words written after the trigger

	always_comb begin
		any_below = 1'b0;
		any_above = 1'b0;
		for (int j = 0; j < digitizer_pkg::N_LANES; j++) begin
			lane[j] = i_samples[j*digitizer_pkg::SAMPLE_W +: digitizer_pkg::SAMPLE_W];
			if (lane[j] < i_lower_thresh) any_below = 1'b1;
			if (lane[j] > i_upper_thresh) any_above = 1'b1;
		end
	end

	// rising edge looks for time over upper, falling for time under lower
	assign tot_hit = (o_acq_state == digitizer_pkg::ACQ_WAIT_HIGH) ? any_above : any_below;
	assign o_wr_en = (o_acq_state != digitizer_pkg::ACQ_READY); // event held, buffer frozen

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_acq_state   <= digitizer_pkg::ACQ_IDLE;
			o_wr_addr     <= '0;
			o_trig_addr   <= '0;
			o_event_count <= '0;
			tot_cnt       <= '0;
			post_cnt      <= '0;
		end else begin
			if (o_wr_en) o_wr_addr <= o_wr_addr + 1'b1; // ring, wraps at 1024
			case (o_acq_state)
				digitizer_pkg::ACQ_IDLE: begin
					tot_cnt  <= '0;
					post_cnt <= '0;
					if (i_arm) begin
						case (i_trig_type)
							digitizer_pkg::TRIG_RISING:  o_acq_state <= digitizer_pkg::ACQ_WAIT_LOW;
							digitizer_pkg::TRIG_FALLING: o_acq_state <= digitizer_pkg::ACQ_WAIT_HIGH_F;
							digitizer_pkg::TRIG_IMMEDIATE: begin
								o_trig_addr <= o_wr_addr; // trigger right here
								o_acq_state <= digitizer_pkg::ACQ_POST;
							end
							default: o_acq_state <= digitizer_pkg::ACQ_IDLE;
						endcase
					end
				end
				digitizer_pkg::ACQ_WAIT_LOW: begin
					if (any_below) o_acq_state <= digitizer_pkg::ACQ_WAIT_HIGH;
				end
				digitizer_pkg::ACQ_WAIT_HIGH_F: begin
					if (any_above) o_acq_state <= digitizer_pkg::ACQ_WAIT_LOW_F;
				end
				digitizer_pkg::ACQ_WAIT_HIGH, digitizer_pkg::ACQ_WAIT_LOW_F: begin
					if (tot_hit) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= i_tot) begin // held for more than i_tot cycles
							o_trig_addr <= o_wr_addr;
							o_acq_state <= digitizer_pkg::ACQ_POST;
						end
					end else begin
						tot_cnt <= '0; // broken run, back to arming condition
						o_acq_state <= (o_acq_state == digitizer_pkg::ACQ_WAIT_HIGH) ?
							digitizer_pkg::ACQ_WAIT_LOW : digitizer_pkg::ACQ_WAIT_HIGH_F;
					end
				end
				digitizer_pkg::ACQ_POST: begin
					if (post_cnt < i_post_len) begin
						post_cnt <= post_cnt + 16'd1;
					end else begin
						o_event_count <= o_event_count + 8'd1;
						o_acq_state   <= digitizer_pkg::ACQ_READY;
					end
				end
				digitizer_pkg::ACQ_READY: begin
					if (i_readout_done) o_acq_state <= digitizer_pkg::ACQ_IDLE;
				end
				default: o_acq_state <= digitizer_pkg::ACQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/cmd_processor.sv ====
//--------------------------------------------------------------------
// decodes one command at a time and streams the reply beats
// readout sends two beats per buffer word, lanes 1/0 then 3/2
// unknown opcodes are dropped without a reply
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_processor (
	input  logic                                      clk,
	input  logic                                      rstn,
	input  logic                                      i_cmd_valid,
	input  digitizer_pkg::cmd_word_u                  i_cmd,
	output logic                                      o_cmd_done,
	// acquisition control and status
	output logic                                      o_arm,
	output logic [7:0]                                o_trig_type,
	output logic signed [digitizer_pkg::SAMPLE_W-1:0] o_lower_thresh,
	output logic signed [digitizer_pkg::SAMPLE_W-1:0] o_upper_thresh,
	output logic [7:0]                                o_tot,
	output logic [15:0]                               o_post_len,
	output logic                                      o_readout_done,
	input  logic [7:0]                                i_acq_state,
	input  logic [7:0]                                i_event_count,
	input  logic [digitizer_pkg::BUF_ADDR_W-1:0]      i_trig_addr,
	// buffer read port
	output logic                                      o_rd_en,
	output logic [digitizer_pkg::BUF_ADDR_W-1:0]      o_rd_addr,
	input  logic [digitizer_pkg::WORD_W-1:0]          i_rd_data,
	// reply stream
	output logic                                      o_tx_valid,
	output logic [digitizer_pkg::BEAT_W-1:0]          o_tx_data,
	output logic [digitizer_pkg::KEEP_W-1:0]          o_tx_keep,
	output logic                                      o_tx_last,
	input  logic                                      i_tx_ready
);

	localparam int SW = digitizer_pkg::SAMPLE_W;
	localparam int PW = digitizer_pkg::PAD_W;

	logic [2:0]  state;
	logic [31:0] bytes_left;  // includes the beat on the bus
	logic        final_beat;
	logic [digitizer_pkg::BUF_ADDR_W-1:0] pre_offset; // words shown before the trigger
	logic [SW-1:0] level_x;   // settings level, widened
	logic [SW-1:0] hyst_x;    // settings hysteresis, widened
	logic [digitizer_pkg::BEAT_W-1:0] beat_lo;  // lanes 1 and 0
	logic [digitizer_pkg::BEAT_W-1:0] beat_hi;  // lanes 3 and 2

	assign level_x = {4'd0, i_cmd.settings.level};
	assign hyst_x  = {4'd0, i_cmd.settings.hyst};
	assign beat_lo = {{PW{1'b0}}, i_rd_data[1*SW +: SW], {PW{1'b0}}, i_rd_data[0*SW +: SW]};
	assign beat_hi = {{PW{1'b0}}, i_rd_data[3*SW +: SW], {PW{1'b0}}, i_rd_data[2*SW +: SW]};

	// keep and last follow the remaining byte count, stable while stalled
	assign final_beat = (bytes_left <= 32'd4);
	assign o_tx_last  = final_beat;
	always_comb begin
		case (bytes_left)
			32'd1:   o_tx_keep = 4'b0001;
			32'd2:   o_tx_keep = 4'b0011;
			32'd3:   o_tx_keep = 4'b0111;
			default: o_tx_keep = 4'b1111;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= digitizer_pkg::CP_IDLE;
			o_cmd_done     <= 1'b0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			o_rd_en        <= 1'b0;
			o_tx_valid     <= 1'b0;
			o_tx_data      <= '0;
			o_rd_addr      <= '0;
			bytes_left     <= '0;
			pre_offset     <= '0;
			o_trig_type    <= '0;
			o_lower_thresh <= '0;
			o_upper_thresh <= '0;
			o_tot          <= '0;
			o_post_len     <= '0;
		end else begin
			o_cmd_done     <= 1'b0; // pulses
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			case (state)
				digitizer_pkg::CP_IDLE: if (i_cmd_valid) begin
					bytes_left <= 32'd4; // one word reply by default
					o_tx_valid <= 1'b1;
					state      <= digitizer_pkg::CP_REPLY;
					case (i_cmd.readout.opcode)
						digitizer_pkg::OP_READOUT: begin
							bytes_left <= i_cmd.readout.length;
							o_tx_valid <= 1'b0;
							o_rd_addr  <= i_trig_addr - pre_offset; // ring wrap
							if (i_cmd.readout.length == 32'd0) begin
								o_cmd_done     <= 1'b1; // nothing to send
								o_readout_done <= 1'b1;
								state          <= digitizer_pkg::CP_IDLE;
							end else begin
								o_rd_en <= 1'b1;
								state   <= digitizer_pkg::CP_RD_WAIT;
							end
						end
						digitizer_pkg::OP_ARM: begin
							o_trig_type <= i_cmd.arm.trig_type;
							o_post_len  <= i_cmd.arm.post_len;
							if (i_acq_state == digitizer_pkg::ACQ_IDLE) o_arm <= 1'b1;
							o_tx_data <= {i_event_count, 16'd0, i_acq_state}; // status
						end
						digitizer_pkg::OP_VERSION: o_tx_data <= digitizer_pkg::VERSION;
						digitizer_pkg::OP_TRIG_SET: begin
							o_lower_thresh <= ((level_x - hyst_x - 12'd128) << 4) + 12'd8;
							o_upper_thresh <= ((level_x + hyst_x - 12'd128) << 4) + 12'd8;
							pre_offset <= {i_cmd.settings.preoff_hi, i_cmd.settings.preoff_lo};
							o_tot      <= i_cmd.settings.tot;
							o_tx_data  <= {24'd0, digitizer_pkg::OP_TRIG_SET}; // echo 8
						end
						default: begin
							o_tx_valid <= 1'b0; // unknown, no reply
							o_cmd_done <= 1'b1;
							state      <= digitizer_pkg::CP_IDLE;
						end
					endcase
				end
				digitizer_pkg::CP_REPLY: if (i_tx_ready) begin
					o_tx_valid <= 1'b0;
					o_cmd_done <= 1'b1;
					bytes_left <= '0;
					state      <= digitizer_pkg::CP_IDLE;
				end
				digitizer_pkg::CP_RD_WAIT: begin
					o_rd_en <= 1'b0; // buffer samples the address this cycle
					state   <= digitizer_pkg::CP_RD_LOAD;
				end
				digitizer_pkg::CP_RD_LOAD: begin
					o_tx_data  <= beat_lo;
					o_tx_valid <= 1'b1;
					state      <= digitizer_pkg::CP_BEAT_LO;
				end
				digitizer_pkg::CP_BEAT_LO, digitizer_pkg::CP_BEAT_HI: if (i_tx_ready) begin
					bytes_left <= bytes_left - 32'd4;
					if (final_beat) begin
						bytes_left     <= '0;
						o_tx_valid     <= 1'b0;
						o_cmd_done     <= 1'b1;
						o_readout_done <= 1'b1; // release the held event
						state          <= digitizer_pkg::CP_IDLE;
					end else if (state == digitizer_pkg::CP_BEAT_LO) begin
						o_tx_data <= beat_hi; // same word, upper lanes
						state     <= digitizer_pkg::CP_BEAT_HI;
					end else begin
						o_tx_valid <= 1'b0;
						o_rd_addr  <= o_rd_addr + 1'b1; // next word
						o_rd_en    <= 1'b1;
						state      <= digitizer_pkg::CP_RD_WAIT;
					end
				end
				default: state <= digitizer_pkg::CP_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/cmd_receiver.sv ====
//--------------------------------------------------------------------
// collects eight stream bytes into one command word
// a new command is accepted only after i_cmd_done
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_receiver (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     i_rx_valid,
	input  logic [7:0]               i_rx_data,
	output logic                     o_rx_ready,
	output logic                     o_cmd_valid,
	output digitizer_pkg::cmd_word_u o_cmd,
	input  logic                     i_cmd_done
);

	logic [2:0] byte_cnt; // bytes taken of the current command
	logic       busy;     // command handed over, waiting for done
	logic       rx_fire;

	assign rx_fire = i_rx_valid & o_rx_ready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_rx_ready  <= 1'b0;
			o_cmd_valid <= 1'b0;
			byte_cnt    <= '0;
			busy        <= 1'b0;
		end else begin
			o_cmd_valid <= 1'b0; // one cycle pulse
			if (rx_fire) begin
				byte_cnt <= byte_cnt + 3'd1; // wraps back to 0 after the eighth
				if (byte_cnt == 3'd7) begin
					o_rx_ready  <= 1'b0;
					o_cmd_valid <= 1'b1;
					busy        <= 1'b1;
				end
			end else if (i_cmd_done) begin
				busy       <= 1'b0;
				o_rx_ready <= 1'b1;
			end else if (!busy) begin
				o_rx_ready <= 1'b1; // first cycle out of reset
			end
		end
	end

	// shift in from the top, first byte ends up in bits 7:0
	always_ff @(posedge clk) begin
		if (rx_fire) o_cmd <= {i_rx_data, o_cmd[63:8]};
	end

endmodule

`default_nettype wire

// ==== logic/digitizer_pkg.sv ====
//--------------------------------------------------------------------
// widths, opcodes and state codes shared by the digitizer core
// the command word holds the first received byte in bits 7:0
//--------------------------------------------------------------------
`default_nettype none

package digitizer_pkg;

	localparam int SAMPLE_W   = 12;                  // one adc sample, signed
	localparam int N_LANES    = 4;                   // samples per clock
	localparam int WORD_W     = N_LANES * SAMPLE_W;  // one buffer word
	localparam int BUF_ADDR_W = 10;                  // 1024 buffer words
	localparam int BEAT_W     = 32;                  // reply beat
	localparam int KEEP_W     = BEAT_W / 8;          // one keep bit per byte
	localparam int PAD_W      = BEAT_W / 2 - SAMPLE_W; // zero pad above a sample

	localparam logic [SAMPLE_W-1:0] SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}}; // -2048
	localparam logic [SAMPLE_W-1:0] SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}}; // 2047

	localparam logic [BEAT_W-1:0] VERSION = 32'd18; // firmware version

	// opcodes, first command byte
	localparam logic [7:0] OP_READOUT  = 8'd0;
	localparam logic [7:0] OP_ARM      = 8'd1;
	localparam logic [7:0] OP_VERSION  = 8'd2;
	localparam logic [7:0] OP_TRIG_SET = 8'd8;

	// trigger types
	localparam logic [7:0] TRIG_IMMEDIATE = 8'd0;
	localparam logic [7:0] TRIG_RISING    = 8'd1;
	localparam logic [7:0] TRIG_FALLING   = 8'd2;

	// acquisition states, codes seen by the host in the arm reply
	localparam logic [7:0] ACQ_IDLE        = 8'd0;
	localparam logic [7:0] ACQ_WAIT_LOW    = 8'd1;   // rising, wait below lower
	localparam logic [7:0] ACQ_WAIT_HIGH   = 8'd2;   // rising, time over upper
	localparam logic [7:0] ACQ_WAIT_HIGH_F = 8'd3;   // falling, wait above upper
	localparam logic [7:0] ACQ_WAIT_LOW_F  = 8'd4;   // falling, time under lower
	localparam logic [7:0] ACQ_POST        = 8'd250; // post-trigger recording
	localparam logic [7:0] ACQ_READY       = 8'd251; // event held for readout

	// command processor states
	localparam logic [2:0] CP_IDLE    = 3'd0;
	localparam logic [2:0] CP_REPLY   = 3'd1;
	localparam logic [2:0] CP_RD_WAIT = 3'd2;
	localparam logic [2:0] CP_RD_LOAD = 3'd3;
	localparam logic [2:0] CP_BEAT_LO = 3'd4;
	localparam logic [2:0] CP_BEAT_HI = 3'd5;

	// one 8-byte command word, three views selected by the opcode
	typedef union packed {
		struct packed {
			logic [31:0] length;    // bytes 7..4, byte count to read
			logic [23:0] rsvd;
			logic [7:0]  opcode;
		} readout;
		struct packed {
			logic [15:0] rsvd_hi;
			logic [15:0] post_len;  // bytes 5..4, words after trigger
			logic [15:0] rsvd_lo;
			logic [7:0]  trig_type; // byte 1
			logic [7:0]  opcode;
		} arm;
		struct packed {
			logic [15:0] rsvd_hi;
			logic [7:0]  tot;       // byte 5, time over threshold
			logic [7:0]  preoff_lo; // byte 4
			logic [5:0]  rsvd_lo;
			logic [1:0]  preoff_hi; // low bits of byte 3
			logic [7:0]  hyst;      // byte 2
			logic [7:0]  level;     // byte 1
			logic [7:0]  opcode;
		} settings;
	} cmd_word_u;

endpackage

`default_nettype wire

// ==== logic/digitizer_top.sv ====
//--------------------------------------------------------------------
// digitizer command core, single clock domain
// host byte stream in, 32-bit reply beats out
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module digitizer_top (
	input  logic                             clk,
	input  logic                             rstn,
	// host command stream
	input  logic                             i_rx_valid,
	input  logic [7:0]                       i_rx_data,
	output logic                             o_rx_ready,
	// host reply stream
	output logic                             o_tx_valid,
	output logic [digitizer_pkg::BEAT_W-1:0] o_tx_data,
	output logic [digitizer_pkg::KEEP_W-1:0] o_tx_keep,
	output logic                             o_tx_last,
	input  logic                             i_tx_ready,
	// adc front end, four lanes per clock
	input  logic [digitizer_pkg::WORD_W-1:0] i_adc_samples
);

	//------------------------------------------------------------------
	// internal wires
	//------------------------------------------------------------------
	digitizer_pkg::cmd_word_u cmd;
	logic cmd_valid, cmd_done;
	logic [digitizer_pkg::WORD_W-1:0] samples, rd_data;
	logic wr_en, rd_en, arm, readout_done;
	logic [digitizer_pkg::BUF_ADDR_W-1:0] wr_addr, rd_addr, trig_addr;
	logic [7:0] acq_state, event_count, trig_type, tot;
	logic [15:0] post_len;
	logic signed [digitizer_pkg::SAMPLE_W-1:0] lower_thresh, upper_thresh;

	cmd_receiver u_rx (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .o_rx_ready(o_rx_ready),
		.o_cmd_valid(cmd_valid), .o_cmd(cmd), .i_cmd_done(cmd_done)
	);

	sample_frontend u_fe (.clk(clk), .i_adc_samples(i_adc_samples), .o_samples(samples));

	acq_trigger u_acq (
		.clk(clk), .rstn(rstn), .i_samples(samples),
		.i_arm(arm), .i_trig_type(trig_type),
		.i_lower_thresh(lower_thresh), .i_upper_thresh(upper_thresh),
		.i_tot(tot), .i_post_len(post_len), .i_readout_done(readout_done),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_acq_state(acq_state),
		.o_event_count(event_count), .o_trig_addr(trig_addr)
	);

	sample_buffer u_buf (
		.clk(clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(samples),
		.i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	cmd_processor u_proc (
		.clk(clk), .rstn(rstn),
		.i_cmd_valid(cmd_valid), .i_cmd(cmd), .o_cmd_done(cmd_done),
		.o_arm(arm), .o_trig_type(trig_type),
		.o_lower_thresh(lower_thresh), .o_upper_thresh(upper_thresh),
		.o_tot(tot), .o_post_len(post_len), .o_readout_done(readout_done),
		.i_acq_state(acq_state), .i_event_count(event_count), .i_trig_addr(trig_addr),
		.o_rd_en(rd_en), .o_rd_addr(rd_addr), .i_rd_data(rd_data),
		.o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_keep(o_tx_keep),
		.o_tx_last(o_tx_last), .i_tx_ready(i_tx_ready)
	);

endmodule

`default_nettype wire

// ==== logic/sample_buffer.sv ====
//--------------------------------------------------------------------
// simple dual-port ring memory, read data one cycle after address
// o_rd_data holds while i_rd_en is low
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_buffer (
	input  logic                                 clk,
	input  logic                                 i_wr_en,
	input  logic [digitizer_pkg::BUF_ADDR_W-1:0] i_wr_addr,
	input  logic [digitizer_pkg::WORD_W-1:0]     i_wr_data,
	input  logic                                 i_rd_en,
	input  logic [digitizer_pkg::BUF_ADDR_W-1:0] i_rd_addr,
	output logic [digitizer_pkg::WORD_W-1:0]     o_rd_data
);

	// block ram sized storage
	logic [digitizer_pkg::WORD_W-1:0] mem [2**digitizer_pkg::BUF_ADDR_W];

	always_ff @(posedge clk) begin
		if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
		if (i_rd_en) o_rd_data <= mem[i_rd_addr]; // registered read port
	end

endmodule

`default_nettype wire

// ==== logic/sample_frontend.sv ====
//--------------------------------------------------------------------
// inverts the four adc lanes, one cycle latency
// -2048 has no positive twin and saturates to 2047
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_frontend (
	input  logic                             clk,
	input  logic [digitizer_pkg::WORD_W-1:0] i_adc_samples,
	output logic [digitizer_pkg::WORD_W-1:0] o_samples
);

	localparam int SW = digitizer_pkg::SAMPLE_W;

	for (genvar j = 0; j < digitizer_pkg::N_LANES; j++) begin : g_lane
		logic [SW-1:0] raw; // lane as delivered, input is inverted
		logic [SW-1:0] neg; // saturated negation

		assign raw = i_adc_samples[j*SW +: SW];
		assign neg = (raw == digitizer_pkg::SAMPLE_MIN) ? digitizer_pkg::SAMPLE_MAX : -raw;

		always_ff @(posedge clk) begin
			o_samples[j*SW +: SW] <= neg; // registered lane
		end
	end

endmodule

`default_nettype wire
